// File: hdl/sram_adapter_pkg.sv
/*
 * widths, typedefs and enums shared by the TileLink to SRAM bridge
 * A/D opcodes, request kinds, atomic FSM states and ALU function codes
 */
`default_nettype none

package sram_adapter_pkg;

  // bus geometry
  localparam int TlDw     = 32;
  localparam int TlDbw    = 4;
  localparam int TlAw     = 32;
  localparam int TlSzw    = 2;
  localparam int TlAiw    = 8;
  localparam int SramAw   = 10;
  localparam int RspDepth = 4;

  // response FIFO pointer and occupancy widths
  localparam int RspPtrW = $clog2(RspDepth);
  localparam int RspCntW = $clog2(RspDepth + 1);

  typedef logic [TlDw-1:0]   tl_data_t;
  typedef logic [TlDbw-1:0]  tl_mask_t;
  typedef logic [TlAw-1:0]   tl_addr_t;
  typedef logic [TlSzw-1:0]  tl_size_t;
  typedef logic [TlAiw-1:0]  tl_source_t;
  typedef logic [2:0]        tl_param_t;
  typedef logic [SramAw-1:0] sram_addr_t;

  // A channel opcodes, TileLink encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // request class after decode
  typedef enum logic [1:0] {
    KindRead,
    KindWrite,
    KindAtomic,
    KindError
  } req_kind_e;

  // read-modify-write sequencer
  typedef enum logic [1:0] {
    AtIdle,
    AtRead,
    AtWrite
  } atomic_state_e;

  // logical atomics, carried in a_param
  localparam tl_param_t AluXor  = 3'd0;
  localparam tl_param_t AluOr   = 3'd1;
  localparam tl_param_t AluAnd  = 3'd2;
  localparam tl_param_t AluSwap = 3'd3;

  // arithmetic atomics, carried in a_param
  localparam tl_param_t AluMin  = 3'd0;
  localparam tl_param_t AluMax  = 3'd1;
  localparam tl_param_t AluMinu = 3'd2;
  localparam tl_param_t AluMaxu = 3'd3;
  localparam tl_param_t AluAdd  = 3'd4;

endpackage

`default_nettype wire

// File: hdl/atomic_alu.sv
/*
 * logical and arithmetic atomic operations on one TL word
 */
`timescale 1ns/1ps
`default_nettype none

module atomic_alu import sram_adapter_pkg::*; (
  // 1 for LogicalData, 0 for ArithmeticData
  input  wire logic      logical_i,
  input  wire tl_param_t function_i,
  // op1 is the A channel operand, op2 the word held in the SRAM
  input  wire tl_data_t  op1_i,
  input  wire tl_data_t  op2_i,
  output tl_data_t       result_o
);

  logic     lt_signed;
  logic     lt_unsigned;
  tl_data_t sum;

  // compares cover the full word regardless of the mask
  assign lt_signed   = $signed(op1_i) < $signed(op2_i);
  assign lt_unsigned = op1_i < op2_i;
  assign sum         = op1_i + op2_i;

  always_comb begin
    // unknown codes leave the stored word unchanged
    result_o = op2_i;
    if (logical_i) begin
      case (function_i)
        AluXor:  result_o = op1_i ^ op2_i;
        AluOr:   result_o = op1_i | op2_i;
        AluAnd:  result_o = op1_i & op2_i;
        AluSwap: result_o = op1_i;
        default: ;
      endcase
    end else begin
      case (function_i)
        AluMin:  result_o = lt_signed ? op1_i : op2_i;
        AluMax:  result_o = lt_signed ? op2_i : op1_i;
        AluMinu: result_o = lt_unsigned ? op1_i : op2_i;
        AluMaxu: result_o = lt_unsigned ? op2_i : op1_i;
        // wraps, no carry out
        AluAdd:  result_o = sum;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/tl_req_decode.sv
/*
 * stage 1 of the bridge: A request classification and a_ready
 */
`timescale 1ns/1ps
`default_nettype none

module tl_req_decode import sram_adapter_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // A channel control
  input  wire logic      a_valid_i,
  input  wire tl_a_op_e  a_opcode_i,
  input  wire tl_size_t  a_size_i,
  output logic           a_ready_o,
  // SRAM grant for the access that goes out with this beat
  input  wire logic      gnt_i,
  // room in the response queue, two free entries at least
  input  wire logic      credit_i,
  // atomic still owns the SRAM
  input  wire logic      busy_i,
  output logic           accept_o,
  output req_kind_e      kind_o
);

  // largest size handled in a single beat, log2 of the byte lanes
  localparam tl_size_t WordSize = tl_size_t'($clog2(TlDbw));

  logic ready_en_q;
  logic path_free;

  // holds a_ready low in the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  // opcode and size classification
  always_comb begin
    case (a_opcode_i)
      Get: begin
        kind_o = KindRead;
      end
      PutFullData, PutPartialData: begin
        kind_o = KindWrite;
      end
      ArithmeticData, LogicalData: begin
        kind_o = KindAtomic;
      end
      default: begin
        kind_o = KindError;
      end
    endcase
    // bursts are not supported, answered with an error
    if (a_size_i > WordSize) begin
      kind_o = KindError;
    end
  end

  // response slot reserved and no atomic in progress
  assign path_free = ready_en_q && credit_i && !busy_i;

  // error requests skip the SRAM, so they need no grant
  assign a_ready_o = path_free && (gnt_i || (kind_o == KindError));

  // one pulse per A transfer
  assign accept_o = a_valid_i && a_ready_o;

endmodule

`default_nettype wire

// File: hdl/sram_access.sv
/*
 * stage 2 of the bridge: SRAM request, in-flight tag, atomic FSM
 * and the response push toward the D queue
 */
`timescale 1ns/1ps
`default_nettype none

module sram_access import sram_adapter_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // from decode
  input  wire logic       accept_i,
  input  wire req_kind_e  kind_i,
  // live A request fields
  input  wire logic       a_valid_i,
  input  wire tl_a_op_e   a_opcode_i,
  input  wire tl_param_t  a_param_i,
  input  wire tl_size_t   a_size_i,
  input  wire tl_source_t a_source_i,
  input  wire tl_addr_t   a_address_i,
  input  wire tl_mask_t   a_mask_i,
  input  wire tl_data_t   a_data_i,
  // SRAM port
  output logic            req_o,
  input  wire logic       gnt_i,
  output logic            we_o,
  output sram_addr_t      addr_o,
  output tl_data_t        wdata_o,
  output tl_data_t        wmask_o,
  input  wire tl_data_t   rdata_i,
  input  wire logic       rvalid_i,
  input  wire logic [1:0] rerror_i,
  // to decode
  output logic            busy_o,
  // to the response queue
  output logic            push_o,
  output req_kind_e       push_kind_o,
  output tl_source_t      push_source_o,
  output tl_size_t        push_size_o,
  output tl_data_t        push_data_o,
  output logic            push_error_o
);

  atomic_state_e state_q, state_d;

  // in-flight tag, one request deep
  logic       pend_q;
  req_kind_e  kind_q;
  tl_source_t source_q;
  tl_size_t   size_q;
  tl_mask_t   mask_q;
  tl_data_t   operand_q;
  tl_param_t  param_q;
  logic       logical_q;
  sram_addr_t addr_q;
  // old word kept while the atomic write waits for its grant
  tl_data_t   old_q;

  tl_data_t a_bitmask;
  tl_data_t tag_bitmask;
  tl_data_t mem_word;
  tl_data_t alu_result;
  logic     rd_kind;

  // byte lanes to bit lanes
  always_comb begin
    for (int i = 0; i < TlDbw; i++) begin
      a_bitmask[8*i +: 8]   = {8{a_mask_i[i]}};
      tag_bitmask[8*i +: 8] = {8{mask_q[i]}};
    end
  end

  // rdata is only there in the AtRead cycle
  assign mem_word = (state_q == AtWrite) ? old_q : rdata_i;

  atomic_alu u_alu (
    .logical_i  (logical_q),
    .function_i (param_q),
    .op1_i      (operand_q),
    .op2_i      (mem_word),
    .result_o   (alu_result)
  );

  // SRAM drive: live A beat when idle, write-back otherwise
  always_comb begin
    req_o   = 1'b0;
    we_o    = 1'b0;
    addr_o  = a_address_i[2 +: SramAw];
    wdata_o = '0;
    wmask_o = '0;
    case (state_q)
      AtIdle: begin
        // atomics start with a plain read of the word
        req_o = accept_i && (kind_i != KindError);
        we_o  = accept_i && (kind_i == KindWrite);
        if (a_valid_i) begin
          wdata_o = a_data_i & a_bitmask;
          wmask_o = a_bitmask;
        end
      end
      AtRead, AtWrite: begin
        req_o   = 1'b1;
        we_o    = 1'b1;
        addr_o  = addr_q;
        // only the masked bytes take the ALU result
        wdata_o = alu_result & tag_bitmask;
        wmask_o = tag_bitmask;
      end
      default: ;
    endcase
  end

  // atomic sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      AtIdle: begin
        if (accept_i && (kind_i == KindAtomic)) begin
          state_d = AtRead;
        end
      end
      AtRead: begin
        state_d = gnt_i ? AtIdle : AtWrite;
      end
      AtWrite: begin
        if (gnt_i) begin
          state_d = AtIdle;
        end
      end
      default: begin
        state_d = AtIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AtIdle;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      pend_q  <= accept_i;
    end
  end

  // tag capture on acceptance
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      kind_q    <= kind_i;
      source_q  <= a_source_i;
      size_q    <= a_size_i;
      mask_q    <= a_mask_i;
      operand_q <= a_data_i;
      param_q   <= a_param_i;
      logical_q <= (a_opcode_i == LogicalData);
      addr_q    <= a_address_i[2 +: SramAw];
    end
    if (state_q == AtRead) begin
      old_q <= rdata_i;
    end
  end

  assign busy_o = (state_q != AtIdle);

  // reads and atomics wait for rvalid, one cycle after acceptance anyway
  assign rd_kind       = (kind_q == KindRead) || (kind_q == KindAtomic);
  assign push_o        = pend_q && (!rd_kind || rvalid_i);
  assign push_kind_o   = kind_q;
  assign push_source_o = source_q;
  assign push_size_o   = size_q;
  // masked-off bytes return zero
  assign push_data_o   = rd_kind ? (rdata_i & tag_bitmask) : '0;
  // uncorrectable error only
  assign push_error_o  = rd_kind && rerror_i[1];

endmodule

`default_nettype wire

// File: hdl/tl_rsp_queue.sv
/*
 * stage 3 of the bridge: in-order response FIFO driving the D channel
 */
`timescale 1ns/1ps
`default_nettype none

module tl_rsp_queue import sram_adapter_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // push side from the SRAM stage
  input  wire logic       push_i,
  input  wire req_kind_e  push_kind_i,
  input  wire tl_source_t push_source_i,
  input  wire tl_size_t   push_size_i,
  input  wire tl_data_t   push_data_i,
  input  wire logic       push_error_i,
  // at least two free entries
  output logic            credit_o,
  // D channel
  output logic            d_valid_o,
  input  wire logic       d_ready_i,
  output tl_d_op_e        d_opcode_o,
  output tl_size_t        d_size_o,
  output tl_source_t      d_source_o,
  output tl_data_t        d_data_o,
  output logic            d_error_o
);

  // entry storage
  tl_d_op_e   opcode_mem [RspDepth];
  tl_size_t   size_mem   [RspDepth];
  tl_source_t source_mem [RspDepth];
  tl_data_t   data_mem   [RspDepth];
  logic       error_mem  [RspDepth];

  logic [RspPtrW-1:0] wr_ptr_q;
  logic [RspPtrW-1:0] rd_ptr_q;
  logic [RspCntW-1:0] count_q;

  tl_d_op_e push_opcode;
  logic     push_err;
  logic     pop;

  function automatic logic [RspPtrW-1:0] ptr_inc(input logic [RspPtrW-1:0] ptr);
    return (ptr == RspPtrW'(RspDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // data-carrying ack for reads and atomics
  assign push_opcode = ((push_kind_i == KindRead) || (push_kind_i == KindAtomic)) ?
                       AccessAckData : AccessAck;
  assign push_err    = (push_kind_i == KindError) || push_error_i;

  assign pop = d_valid_o && d_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      opcode_mem[wr_ptr_q] <= push_opcode;
      size_mem[wr_ptr_q]   <= push_size_i;
      source_mem[wr_ptr_q] <= push_source_i;
      data_mem[wr_ptr_q]   <= push_data_i;
      error_mem[wr_ptr_q]  <= push_err;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // one slot for the response in flight, one for the next acceptance
  assign credit_o = (count_q <= RspCntW'(RspDepth - 2));

  // head entry straight from the storage flops
  assign d_valid_o  = (count_q != '0);
  assign d_opcode_o = opcode_mem[rd_ptr_q];
  assign d_size_o   = size_mem[rd_ptr_q];
  assign d_source_o = source_mem[rd_ptr_q];
  assign d_data_o   = data_mem[rd_ptr_q];
  assign d_error_o  = error_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: hdl/tl_sram_adapter.sv
/*
 * TileLink A/D to single-port SRAM bridge, three pipeline stages
 */
`timescale 1ns/1ps
`default_nettype none

module tl_sram_adapter import sram_adapter_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // A channel
  input  wire logic       a_valid_i,
  output logic            a_ready_o,
  input  wire tl_a_op_e   a_opcode_i,
  input  wire tl_param_t  a_param_i,
  input  wire tl_size_t   a_size_i,
  input  wire tl_source_t a_source_i,
  input  wire tl_addr_t   a_address_i,
  input  wire tl_mask_t   a_mask_i,
  input  wire tl_data_t   a_data_i,
  // D channel
  output logic            d_valid_o,
  input  wire logic       d_ready_i,
  output tl_d_op_e        d_opcode_o,
  output tl_size_t        d_size_o,
  output tl_source_t      d_source_o,
  output tl_data_t        d_data_o,
  output logic            d_error_o,
  // SRAM
  output logic            req_o,
  input  wire logic       gnt_i,
  output logic            we_o,
  output sram_addr_t      addr_o,
  output tl_data_t        wdata_o,
  output tl_data_t        wmask_o,
  input  wire tl_data_t   rdata_i,
  input  wire logic       rvalid_i,
  // bit 1 uncorrectable, bit 0 correctable
  input  wire logic [1:0] rerror_i
);

  logic       accept;
  req_kind_e  kind;
  logic       busy;
  logic       credit;
  logic       push;
  req_kind_e  push_kind;
  tl_source_t push_source;
  tl_size_t   push_size;
  tl_data_t   push_data;
  logic       push_error;

  tl_req_decode u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .a_valid_i  (a_valid_i),
    .a_opcode_i (a_opcode_i),
    .a_size_i   (a_size_i),
    .a_ready_o  (a_ready_o),
    .gnt_i      (gnt_i),
    .credit_i   (credit),
    .busy_i     (busy),
    .accept_o   (accept),
    .kind_o     (kind)
  );

  sram_access u_access (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .kind_i        (kind),
    .a_valid_i     (a_valid_i),
    .a_opcode_i    (a_opcode_i),
    .a_param_i     (a_param_i),
    .a_size_i      (a_size_i),
    .a_source_i    (a_source_i),
    .a_address_i   (a_address_i),
    .a_mask_i      (a_mask_i),
    .a_data_i      (a_data_i),
    .req_o         (req_o),
    .gnt_i         (gnt_i),
    .we_o          (we_o),
    .addr_o        (addr_o),
    .wdata_o       (wdata_o),
    .wmask_o       (wmask_o),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .rerror_i      (rerror_i),
    .busy_o        (busy),
    .push_o        (push),
    .push_kind_o   (push_kind),
    .push_source_o (push_source),
    .push_size_o   (push_size),
    .push_data_o   (push_data),
    .push_error_o  (push_error)
  );

  tl_rsp_queue u_rsp_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .push_kind_i   (push_kind),
    .push_source_i (push_source),
    .push_size_i   (push_size),
    .push_data_i   (push_data),
    .push_error_i  (push_error),
    .credit_o      (credit),
    .d_valid_o     (d_valid_o),
    .d_ready_i     (d_ready_i),
    .d_opcode_o    (d_opcode_o),
    .d_size_o      (d_size_o),
    .d_source_o    (d_source_o),
    .d_data_o      (d_data_o),
    .d_error_o     (d_error_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
/*
 * clock and reset generator for the bridge testbench
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period, first rising edge at 5 ns
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // clean falling edge at 1 ns, released on a falling clock edge
  initial begin
    rst_no = 1'b1;
    #1 rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
/*
 * response checker with shadow memory, reference model and expected D queue
 * also covers reset values, SRAM port values and D hold under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import sram_adapter_pkg::*; #(
  parameter sram_addr_t PoisonAddr = '0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        a_valid_i,
  input  wire logic        a_ready_i,
  input  wire tl_a_op_e    a_opcode_i,
  input  wire tl_param_t   a_param_i,
  input  wire tl_size_t    a_size_i,
  input  wire tl_source_t  a_source_i,
  input  wire tl_addr_t    a_address_i,
  input  wire tl_mask_t    a_mask_i,
  input  wire tl_data_t    a_data_i,
  input  wire logic        d_valid_i,
  input  wire logic        d_ready_i,
  input  wire tl_d_op_e    d_opcode_i,
  input  wire tl_size_t    d_size_i,
  input  wire tl_source_t  d_source_i,
  input  wire tl_data_t    d_data_i,
  input  wire logic        d_error_i,
  input  wire logic        req_i,
  input  wire logic        we_i,
  input  wire sram_addr_t  addr_i,
  input  wire tl_data_t    wdata_i,
  input  wire tl_data_t    wmask_i,
  output logic [31:0]      errors_o,
  output logic [31:0]      checks_o,
  output logic [31:0]      pending_o
);

  tl_data_t    shadow [1024];
  // {opcode, error, size, source, data}
  logic [45:0] exp_q [$];
  logic [45:0] d_fields;
  logic [45:0] held_q;
  logic [45:0] entry;
  logic        stall_q;
  int          errors;
  int          checks;

  // per-request scratch of the compare process
  logic [2:0]  exp_op;
  logic        exp_err;
  tl_data_t    exp_data;
  tl_data_t    new_word;
  logic        exp_req;
  logic        exp_we;
  tl_data_t    exp_bm;
  sram_addr_t  word_idx;

  assign d_fields  = {d_opcode_i, d_error_i, d_size_i, d_source_i, d_data_i};
  assign errors_o  = errors;
  assign checks_o  = checks;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = '0;
    end
    errors    = 0;
    checks    = 0;
    stall_q   = 1'b0;
    held_q    = '0;
    pending_o = '0;
  end

  // a is the A channel operand, m the stored word
  function automatic tl_data_t alu_ref(input logic logical, input logic [2:0] fn,
                                       input tl_data_t a, input tl_data_t m);
    if (logical) begin
      case (fn)
        3'd0:    return a ^ m;
        3'd1:    return a | m;
        3'd2:    return a & m;
        3'd3:    return a;
        default: return m;
      endcase
    end
    case (fn)
      3'd0:    return ($signed(a) < $signed(m)) ? a : m;
      3'd1:    return ($signed(a) > $signed(m)) ? a : m;
      3'd2:    return (a < m) ? a : m;
      3'd3:    return (a > m) ? a : m;
      3'd4:    return a + m;
      default: return m;
    endcase
  endfunction

  // expected D fields, SRAM strobes and new word for one A beat
  function automatic void ref_model(input logic [2:0] op, input logic [2:0] param,
                                    input logic [1:0] size, input logic [3:0] mask,
                                    input tl_data_t operand, input tl_data_t old,
                                    input logic poison, output logic [2:0] d_op,
                                    output logic d_err, output tl_data_t d_data,
                                    output tl_data_t upd, output logic sram_req,
                                    output logic sram_we);
    tl_data_t bm;
    bm       = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    d_op     = 3'h0;
    d_err    = 1'b0;
    d_data   = '0;
    upd      = old;
    sram_req = 1'b1;
    sram_we  = 1'b0;
    if ((size > 2'd2) || (op > 3'h4)) begin
      // bursts and unknown opcodes never reach the SRAM
      d_err    = 1'b1;
      sram_req = 1'b0;
    end else if (op == 3'h4) begin
      d_op   = 3'h1;
      d_data = old & bm;
      d_err  = poison;
    end else if (op <= 3'h1) begin
      sram_we = 1'b1;
      upd     = (old & ~bm) | (operand & bm);
    end else begin
      // atomics read first, return the old data and store the result in masked bytes
      d_op   = 3'h1;
      d_data = old & bm;
      d_err  = poison;
      upd    = (old & ~bm) | (alu_ref(op == 3'h3, param, operand, old) & bm);
    end
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks = checks + 1;
    if (exp !== got) begin
      errors = errors + 1;
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, got);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      check_field("a_ready_o", 32'd0, a_ready_i);
      check_field("d_valid_o", 32'd0, d_valid_i);
      check_field("req_o", 32'd0, req_i);
      check_field("we_o", 32'd0, we_i);
      stall_q = 1'b0;
    end else begin
      // stalled response must stay put
      if (stall_q) begin
        checks = checks + 1;
        if (!d_valid_i || (d_fields !== held_q)) begin
          errors = errors + 1;
          $display("%0t ns: D response changed or vanished while d_ready was low", $time);
        end
      end
      stall_q = d_valid_i && !d_ready_i;
      held_q  = d_fields;

      if (a_valid_i && a_ready_i) begin
        word_idx = a_address_i[11:2];
        exp_bm   = {{8{a_mask_i[3]}}, {8{a_mask_i[2]}}, {8{a_mask_i[1]}}, {8{a_mask_i[0]}}};
        ref_model(a_opcode_i, a_param_i, a_size_i, a_mask_i, a_data_i, shadow[word_idx],
                  word_idx == PoisonAddr, exp_op, exp_err, exp_data, new_word,
                  exp_req, exp_we);
        check_field("req_o", exp_req, req_i);
        check_field("we_o", exp_we, we_i);
        if (exp_req) begin
          check_field("addr_o", word_idx, addr_i);
        end
        // write data only matters in the enabled byte lanes
        if (exp_we) begin
          check_field("wmask_o", exp_bm, wmask_i);
          check_field("wdata_o", a_data_i & exp_bm, wdata_i & wmask_i);
        end
        shadow[word_idx] = new_word;
        exp_q.push_back({exp_op, exp_err, a_size_i, a_source_i, exp_data});
      end

      if (d_valid_i && d_ready_i) begin
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("%0t ns: D response arrived with no request outstanding", $time);
        end else begin
          entry = exp_q.pop_front();
          check_field("d_opcode_o", entry[45:43], d_opcode_i);
          check_field("d_error_o", entry[42], d_error_i);
          check_field("d_size_o", entry[41:40], d_size_i);
          check_field("d_source_o", entry[39:32], d_source_i);
          check_field("d_data_o", entry[31:0], d_data_i);
        end
      end
      pending_o = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_top.sv
/*
 * top of the bridge testbench with DUT, SRAM model, stimulus and final verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top import sram_adapter_pkg::*; ();

  localparam logic [31:0] Seed       = 32'h4ee6_58fe;
  localparam sram_addr_t  PoisonAddr = 10'h2a5;
  localparam int          WaitLimit  = 200;
  localparam int          DrainLimit = 2000;
  localparam int          NumRandom  = 400;

  logic        clk;
  logic        rst_n;
  logic        a_valid;
  logic        a_ready;
  tl_a_op_e    a_opcode;
  tl_param_t   a_param;
  tl_size_t    a_size;
  tl_source_t  a_source;
  tl_addr_t    a_address;
  tl_mask_t    a_mask;
  tl_data_t    a_data;
  logic        d_valid;
  logic        d_ready = 1'b0;
  tl_d_op_e    d_opcode;
  tl_size_t    d_size;
  tl_source_t  d_source;
  tl_data_t    d_data;
  logic        d_error;
  logic        req;
  logic        gnt = 1'b0;
  logic        we;
  sram_addr_t  addr;
  tl_data_t    wdata;
  tl_data_t    wmask;
  tl_data_t    rdata;
  logic        rvalid;
  logic [1:0]  rerror;

  tl_data_t    sram_mem [1024];
  logic        a_fire_q;
  logic [31:0] stim_rnd;
  logic [31:0] bg_rnd = ~Seed;
  logic        timed_out;
  tl_source_t  src_cnt;
  logic [31:0] errors;
  logic [31:0] checks;
  logic [31:0] pending;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tl_sram_adapter uut (
    .clk_i (clk), .rst_ni (rst_n),
    .a_valid_i (a_valid), .a_ready_o (a_ready), .a_opcode_i (a_opcode),
    .a_param_i (a_param), .a_size_i (a_size), .a_source_i (a_source),
    .a_address_i (a_address), .a_mask_i (a_mask), .a_data_i (a_data),
    .d_valid_o (d_valid), .d_ready_i (d_ready), .d_opcode_o (d_opcode),
    .d_size_o (d_size), .d_source_o (d_source), .d_data_o (d_data),
    .d_error_o (d_error),
    .req_o (req), .gnt_i (gnt), .we_o (we), .addr_o (addr),
    .wdata_o (wdata), .wmask_o (wmask), .rdata_i (rdata),
    .rvalid_i (rvalid), .rerror_i (rerror)
  );

  tb_checker #(.PoisonAddr (PoisonAddr)) u_checker (
    .clk_i (clk), .rst_ni (rst_n),
    .a_valid_i (a_valid), .a_ready_i (a_ready), .a_opcode_i (a_opcode),
    .a_param_i (a_param), .a_size_i (a_size), .a_source_i (a_source),
    .a_address_i (a_address), .a_mask_i (a_mask), .a_data_i (a_data),
    .d_valid_i (d_valid), .d_ready_i (d_ready), .d_opcode_i (d_opcode),
    .d_size_i (d_size), .d_source_i (d_source), .d_data_i (d_data),
    .d_error_i (d_error), .req_i (req), .we_i (we),
    .addr_i (addr), .wdata_i (wdata), .wmask_i (wmask),
    .errors_o (errors), .checks_o (checks), .pending_o (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // single-port SRAM with one cycle read latency where the poisoned word flags rerror[1]
  initial begin
    for (int i = 0; i < 1024; i++) begin
      sram_mem[i] = '0;
    end
    rvalid = 1'b0;
    rerror = 2'b00;
    rdata  = '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rerror <= 2'b00;
      rdata  <= '0;
    end else begin
      rvalid <= 1'b0;
      rerror <= 2'b00;
      if (req && gnt) begin
        if (we) begin
          sram_mem[addr] <= (sram_mem[addr] & ~wmask) | (wdata & wmask);
        end else begin
          rdata  <= sram_mem[addr];
          rvalid <= 1'b1;
          rerror <= {addr == PoisonAddr, 1'b0};
        end
      end
    end
  end

  // A transfer seen at the rising edge and read back by the driver at the falling edge
  always @(posedge clk) begin
    a_fire_q <= a_valid && a_ready;
  end

  // random grant and D back-pressure
  always @(negedge clk) begin
    bg_rnd  = lcg_next(bg_rnd);
    gnt     = (bg_rnd[31:29] < 3'd5);
    d_ready = (bg_rnd[27:25] < 3'd5);
  end

  // present one A beat and hold it until accepted
  task automatic send_req(input tl_a_op_e op, input tl_param_t param, input tl_size_t size,
                          input sram_addr_t word, input tl_mask_t mask, input tl_data_t data);
    int waited;
    if (!timed_out) begin
      waited    = 0;
      a_valid   = 1'b1;
      a_opcode  = op;
      a_param   = param;
      a_size    = size;
      a_source  = src_cnt;
      a_address = {20'h0, word, 2'b00};
      a_mask    = mask;
      a_data    = data;
      src_cnt   = src_cnt + 1'b1;
      do begin
        @(negedge clk);
        waited++;
      end while (!a_fire_q && (waited < WaitLimit));
      a_valid = 1'b0;
      if (!a_fire_q) begin
        timed_out = 1'b1;
        $display("timeout: request with source %0d was never accepted on A", a_source);
      end
    end
  endtask

  task automatic rand_req();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [2:0]  op_code;
    tl_a_op_e    op;
    tl_param_t   param;
    tl_size_t    size;
    sram_addr_t  word;
    tl_mask_t    mask;
    stim_rnd = lcg_next(stim_rnd);
    r1       = stim_rnd;
    stim_rnd = lcg_next(stim_rnd);
    r2       = stim_rnd;
    size     = tl_size_t'(r1[27:26] % 3);
    // small window so that accesses hit the same words often
    word     = (r1[23:20] == 4'h0) ? PoisonAddr : sram_addr_t'(r1[19:16]);
    mask     = r1[15:12];
    param    = '0;
    op       = Get;
    case (r1[31:28])
      4'd4, 4'd5: begin
        op   = PutFullData;
        mask = 4'hf;
      end
      4'd6, 4'd7: op = PutPartialData;
      4'd8, 4'd9: begin
        op    = LogicalData;
        param = tl_param_t'(r1[9:8]);
      end
      4'd10, 4'd11: begin
        op    = ArithmeticData;
        param = tl_param_t'(r1[10:8] % 5);
      end
      4'd12: begin
        // legal opcode with burst size
        op_code = 3'(r1[2:0] % 5);
        op      = tl_a_op_e'(op_code);
        size    = 2'd3;
      end
      4'd13: begin
        op_code = 3'(5 + (r1[1:0] % 3));
        op      = tl_a_op_e'(op_code);
      end
      default: ;
    endcase
    send_req(op, param, size, word, mask, r2);
  endtask

  initial begin
    int waited;
    a_valid   = 1'b0;
    a_opcode  = Get;
    a_param   = '0;
    a_size    = '0;
    a_source  = '0;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    timed_out = 1'b0;
    src_cnt   = '0;
    stim_rnd  = Seed;

    waited = 0;
    while ((rst_n !== 1'b1) && (waited < WaitLimit)) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end

    // known contents for the word window and the poisoned word
    for (int w = 0; w < 16; w++) begin
      stim_rnd = lcg_next(stim_rnd);
      send_req(PutFullData, '0, 2'd2, sram_addr_t'(w), 4'hf, stim_rnd);
    end
    send_req(PutFullData, '0, 2'd2, PoisonAddr, 4'hf, 32'h0bad_f00d);

    // partial write merges into the full word
    send_req(PutFullData, '0, 2'd2, 10'd1, 4'hf, 32'h1122_3344);
    send_req(PutPartialData, '0, 2'd2, 10'd1, 4'b0101, 32'haabb_ccdd);
    send_req(Get, '0, 2'd2, 10'd1, 4'hf, '0);
    send_req(Get, '0, 2'd1, 10'd1, 4'b0011, '0);

    // every logical atomic followed by a read back
    for (int f = 0; f < 4; f++) begin
      send_req(LogicalData, tl_param_t'(f), 2'd2, 10'd2, 4'hf, 32'hf0f0_3c3c);
      send_req(Get, '0, 2'd2, 10'd2, 4'hf, '0);
    end

    // negative stored word separates signed and unsigned compares
    for (int f = 0; f < 5; f++) begin
      send_req(PutFullData, '0, 2'd2, 10'd4, 4'hf, 32'h8000_0005);
      send_req(ArithmeticData, tl_param_t'(f), 2'd2, 10'd4, 4'hf, 32'h0000_0007);
      send_req(Get, '0, 2'd2, 10'd4, 4'hf, '0);
    end
    send_req(ArithmeticData, AluAdd, 2'd2, 10'd4, 4'b1100, 32'h0001_ffff);
    send_req(Get, '0, 2'd2, 10'd4, 4'hf, '0);

    // bursts and unknown opcodes
    send_req(Get, '0, 2'd3, 10'd5, 4'hf, '0);
    send_req(PutFullData, '0, 2'd3, 10'd5, 4'hf, 32'hdead_beef);
    for (int op = 5; op < 8; op++) begin
      send_req(tl_a_op_e'(op[2:0]), '0, 2'd2, 10'd5, 4'hf, 32'h1234_5678);
    end
    send_req(Get, '0, 2'd2, PoisonAddr, 4'hf, '0);

    // random mix with idle gaps
    for (int n = 0; n < NumRandom; n++) begin
      stim_rnd = lcg_next(stim_rnd);
      if (stim_rnd[31:30] == 2'b00) begin
        repeat (stim_rnd[29:28]) @(negedge clk);
      end
      rand_req();
    end

    waited = 0;
    while ((pending != 0) && (waited < DrainLimit)) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) begin
      timed_out = 1'b1;
      $display("timeout: %0d responses never came back on D", pending);
    end

    $display("checks %0d, errors %0d, outstanding %0d", checks, errors, pending);
    if (timed_out || (errors != 0)) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/sram_adapter_pkg.sv
hdl/atomic_alu.sv
hdl/tl_req_decode.sv
hdl/sram_access.sv
hdl/tl_rsp_queue.sv
hdl/tl_sram_adapter.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv
